// File: hw/exu_pkg.sv
package exu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and iteration counts
    //////////////////////////////////////////////////////////////////////

    localparam int xlen = 64;

    // One iteration per operand bit for both the multiplier and the divider.
    localparam int mul_steps = 64;

    //////////////////////////////////////////////////////////////////////
    // Operation codes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        op_add    = 5'd0,
        op_sub    = 5'd1,
        op_pass_a = 5'd2,
        op_pass_b = 5'd3,
        op_xor    = 5'd4,
        op_or     = 5'd5,
        op_and    = 5'd6,
        op_sll    = 5'd7,
        op_srl    = 5'd8,
        op_sra    = 5'd9,
        op_slt    = 5'd10,
        op_sltu   = 5'd11,
        op_eq     = 5'd12,
        op_ge     = 5'd13,
        op_geu    = 5'd14,
        op_mul    = 5'd15,
        op_div    = 5'd16,
        op_divu   = 5'd17,
        op_rem    = 5'd18,
        op_remu   = 5'd19
    } alu_op_t;

    // Operand select codes.
    typedef enum logic {
        sel_a_pc  = 1'b0,
        sel_a_rs1 = 1'b1
    } sel_a_t;

    typedef enum logic [1:0] {
        sel_b_imm = 2'd0,
        sel_b_rs2 = 2'd1,
        sel_b_csr = 2'd2
    } sel_b_t;

endpackage

// File: hw/exu_operand_mux.sv
`timescale 1ns/10ps

module exu_operand_mux import exu_pkg::*; (
    input  sel_a_t            sel_a,
    input  sel_b_t            sel_b,
    input  logic              op_w,
    input  logic [xlen-1:0]   pc,
    input  logic [xlen-1:0]   rs1,
    input  logic [xlen-1:0]   rs2,
    input  logic [xlen-1:0]   csr,
    input  logic [xlen-1:0]   imm,
    output logic [xlen-1:0]   a,
    output logic [xlen-1:0]   b
);

    logic [xlen-1:0] rs1_view;

    // Word ops see only the low half of rs1, zero extended.
    assign rs1_view = op_w ? {{(xlen-32){1'b0}}, rs1[31:0]} : rs1;

    assign a = (sel_a == sel_a_rs1) ? rs1_view : pc;

    always_comb begin
        case (sel_b)
            sel_b_rs2: b = rs2;
            sel_b_csr: b = csr;
            default:   b = imm;
        endcase
    end

endmodule

// File: hw/exu_alu.sv
`timescale 1ns/10ps

module exu_alu import exu_pkg::*; (
    input  alu_op_t           op,
    input  logic              op_w,
    input  logic [xlen-1:0]   a,
    input  logic [xlen-1:0]   b,
    output logic [xlen-1:0]   y
);

    logic [5:0]          shamt;
    logic signed [31:0]  word_sra;
    logic                lt_s;
    logic                lt_u;

    assign shamt = b[5:0];

    // Arithmetic shift of the low word, used by the word form of sra.
    assign word_sra = $signed(a[31:0]) >>> shamt;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        y = '0;
        case (op)
            op_add:    y = a + b;
            op_sub:    y = a - b;
            op_pass_a: y = a;
            op_pass_b: y = b;
            op_xor:    y = a ^ b;
            op_or:     y = a | b;
            op_and:    y = a & b;
            op_sll:    y = a << shamt;
            op_srl:    y = a >> shamt;
            op_sra: begin
                if (op_w) begin
                    y = {{(xlen-32){1'b0}}, word_sra};
                end else begin
                    y = $signed(a) >>> shamt;
                end
            end
            op_slt:    y = {{(xlen-1){1'b0}}, lt_s};
            op_sltu:   y = {{(xlen-1){1'b0}}, lt_u};
            op_eq:     y = {{(xlen-1){1'b0}}, a == b};
            op_ge:     y = {{(xlen-1){1'b0}}, ~lt_s};
            op_geu:    y = {{(xlen-1){1'b0}}, ~lt_u};
            // Multiply and divide results come from their own units.
            default:   y = '0;
        endcase
    end

endmodule

// File: hw/exu_mul.sv
`timescale 1ns/10ps

module exu_mul import exu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              abort,
    input  logic [xlen-1:0]   a,
    input  logic [xlen-1:0]   b,
    output logic              done,
    output logic [xlen-1:0]   p
);

    logic [xlen-1:0]                  mcand;
    logic [xlen-1:0]                  mplier;
    logic [xlen-1:0]                  acc;
    logic [$clog2(mul_steps+1)-1:0]   cnt;
    logic                             running;

    //////////////////////////////////////////////////////////////////////
    // Control: step counter and done pulse
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || abort) begin
            running <= 1'b0;
            cnt     <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                if (cnt == mul_steps) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    // Bits shifted out of the top of the multiplicand fall outside the low
    // product, so the accumulator wraps modulo 2**xlen.
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (running && cnt != mul_steps) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign p = acc;

endmodule

// File: hw/exu_div.sv
`timescale 1ns/10ps

module exu_div import exu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              abort,
    input  alu_op_t           op,
    input  logic [xlen-1:0]   a,
    input  logic [xlen-1:0]   b,
    output logic              done,
    output logic [xlen-1:0]   q
);

    typedef enum logic [1:0] {
        d_idle,
        d_calc,
        d_sign,
        d_out
    } div_state_t;

    div_state_t                       state;
    alu_op_t                          op_q;
    logic [xlen-1:0]                  quo;
    logic [xlen-1:0]                  rem;
    logic [xlen-1:0]                  dvsr;
    logic                             neg_q;
    logic                             neg_r;
    logic [$clog2(mul_steps+1)-1:0]   cnt;

    logic                             sgn;
    logic                             div_zero;
    logic                             overflow;
    logic [xlen-1:0]                  a_mag;
    logic [xlen-1:0]                  b_mag;
    logic [xlen:0]                    rem_sh;
    logic [xlen:0]                    diff;

    assign sgn      = (op == op_div) || (op == op_rem);
    assign div_zero = (b == '0);
    assign overflow = sgn && (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
    assign a_mag    = (sgn && a[xlen-1]) ? -a : a;
    assign b_mag    = (sgn && b[xlen-1]) ? -b : b;

    // One restoring step: shift in the next dividend bit and try to subtract.
    assign rem_sh = {rem, quo[xlen-1]};
    assign diff   = rem_sh - {1'b0, dvsr};

    always_ff @(posedge clk) begin
        if (!rst_n || abort) begin
            state <= d_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                d_idle: begin
                    if (start) begin
                        // The corner cases skip the iterations entirely.
                        state <= (div_zero || overflow) ? d_sign : d_calc;
                    end
                end
                d_calc: begin
                    if (cnt == mul_steps - 1) begin
                        state <= d_sign;
                    end
                end
                d_sign: state <= d_out;
                default: begin
                    done  <= 1'b1;
                    state <= d_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            d_idle: begin
                op_q <= op;
                cnt  <= '0;
                dvsr <= b_mag;
                if (div_zero) begin
                    quo   <= '1;
                    rem   <= a;
                    neg_q <= 1'b0;
                    neg_r <= 1'b0;
                end else if (overflow) begin
                    quo   <= a;
                    rem   <= '0;
                    neg_q <= 1'b0;
                    neg_r <= 1'b0;
                end else begin
                    quo   <= a_mag;
                    rem   <= '0;
                    neg_q <= sgn && (a[xlen-1] ^ b[xlen-1]);
                    neg_r <= sgn && a[xlen-1];
                end
            end
            d_calc: begin
                cnt <= cnt + 1'b1;
                if (!diff[xlen]) begin
                    rem <= diff[xlen-1:0];
                    quo <= {quo[xlen-2:0], 1'b1};
                end else begin
                    rem <= rem_sh[xlen-1:0];
                    quo <= {quo[xlen-2:0], 1'b0};
                end
            end
            d_sign: begin
                if (neg_q) begin
                    quo <= -quo;
                end
                if (neg_r) begin
                    rem <= -rem;
                end
            end
            default: begin
                q <= ((op_q == op_rem) || (op_q == op_remu)) ? rem : quo;
            end
        endcase
    end

endmodule

// File: hw/exu_ctrl.sv
`timescale 1ns/10ps

module exu_ctrl import exu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              in_valid,
    input  alu_op_t           op,
    input  logic [xlen-1:0]   alu_y,
    input  logic [xlen-1:0]   mul_p,
    input  logic              mul_done,
    input  logic [xlen-1:0]   div_q,
    input  logic              div_done,
    output logic              mul_start,
    output logic              div_start,
    output logic              abort,
    output logic [xlen-1:0]   res,
    output logic              out_valid,
    output logic              busy
);

    typedef enum logic [1:0] {
        idle,
        wait_mul,
        wait_div
    } ctrl_state_t;

    ctrl_state_t      state;
    ctrl_state_t      state_next;
    logic             is_mul;
    logic             is_div;
    logic             issue;
    logic             load;
    logic [xlen-1:0]  res_next;

    assign is_mul = (op == op_mul);
    assign is_div = (op == op_div) || (op == op_divu) || (op == op_rem) || (op == op_remu);

    // A flush in the issue cycle cancels the operation before it starts.
    assign issue     = (state == idle) && in_valid && !flush;
    assign mul_start = issue && is_mul;
    assign div_start = issue && is_div;
    assign abort     = flush;
    assign busy      = (state != idle);

    always_comb begin
        state_next = state;
        load       = 1'b0;
        res_next   = alu_y;
        case (state)
            idle: begin
                if (issue) begin
                    if (is_mul) begin
                        state_next = wait_mul;
                    end else if (is_div) begin
                        state_next = wait_div;
                    end else begin
                        load = 1'b1;
                    end
                end
            end
            wait_mul: begin
                res_next = mul_p;
                if (mul_done) begin
                    state_next = idle;
                    load       = 1'b1;
                end
            end
            default: begin
                res_next = div_q;
                if (div_done) begin
                    state_next = idle;
                    load       = 1'b1;
                end
            end
        endcase
        if (flush) begin
            state_next = idle;
            load       = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= idle;
            out_valid <= 1'b0;
        end else begin
            state     <= state_next;
            out_valid <= load;
        end
    end

    // The result holds until the next completed operation.
    always_ff @(posedge clk) begin
        if (load) begin
            res <= res_next;
        end
    end

endmodule

// File: hw/exu_top.sv
`timescale 1ns/10ps

module exu_top import exu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              in_valid,
    input  alu_op_t           op,
    input  sel_a_t            sel_a,
    input  sel_b_t            sel_b,
    input  logic              op_w,
    input  logic [xlen-1:0]   pc,
    input  logic [xlen-1:0]   rs1,
    input  logic [xlen-1:0]   rs2,
    input  logic [xlen-1:0]   csr,
    input  logic [xlen-1:0]   imm,
    output logic [xlen-1:0]   res,
    output logic              out_valid,
    output logic              busy
);

    logic [xlen-1:0]  a;
    logic [xlen-1:0]  b;
    logic [xlen-1:0]  alu_y;
    logic [xlen-1:0]  mul_p;
    logic [xlen-1:0]  div_q;
    logic             mul_start;
    logic             div_start;
    logic             mul_done;
    logic             div_done;
    logic             abort;

    exu_operand_mux u_exu_operand_mux (
        .sel_a (sel_a),
        .sel_b (sel_b),
        .op_w  (op_w),
        .pc    (pc),
        .rs1   (rs1),
        .rs2   (rs2),
        .csr   (csr),
        .imm   (imm),
        .a     (a),
        .b     (b)
    );

    exu_alu u_exu_alu (
        .op   (op),
        .op_w (op_w),
        .a    (a),
        .b    (b),
        .y    (alu_y)
    );

    exu_mul u_exu_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mul_start),
        .abort (abort),
        .a     (a),
        .b     (b),
        .done  (mul_done),
        .p     (mul_p)
    );

    exu_div u_exu_div (
        .clk   (clk),
        .rst_n (rst_n),
        .start (div_start),
        .abort (abort),
        .op    (op),
        .a     (a),
        .b     (b),
        .done  (div_done),
        .q     (div_q)
    );

    exu_ctrl u_exu_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .op        (op),
        .alu_y     (alu_y),
        .mul_p     (mul_p),
        .mul_done  (mul_done),
        .div_q     (div_q),
        .div_done  (div_done),
        .mul_start (mul_start),
        .div_start (div_start),
        .abort     (abort),
        .res       (res),
        .out_valid (out_valid),
        .busy      (busy)
    );

endmodule

// File: tests/exu_tb.sv
`timescale 1ns/10ps

module exu_tb import exu_pkg::*;;

    logic             clk;
    logic             rst_n;
    logic             flush;
    logic             in_valid;
    alu_op_t          op;
    sel_a_t           sel_a;
    sel_b_t           sel_b;
    logic             op_w;
    logic [xlen-1:0]  pc;
    logic [xlen-1:0]  rs1;
    logic [xlen-1:0]  rs2;
    logic [xlen-1:0]  csr;
    logic [xlen-1:0]  imm;
    logic [xlen-1:0]  res;
    logic             out_valid;
    logic             busy;

    logic [31:0]      lfsr_state = 32'h85f4;

    exu_top u_exu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .op        (op),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .op_w      (op_w),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .res       (res),
        .out_valid (out_valid),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Random bits, failure reporting and the reference model
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32, 22, 2 and 1. It steps once per bit taken.
    function automatic logic [xlen-1:0] rand_bits(input int n);
        logic [xlen-1:0] v;
        logic            fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[xlen-2:0], fb};
        end
        return v;
    endfunction

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        assert (got === exp) else
            stop_on_failure($sformatf("Error at %0t ns: %s expected %h, got %h",
                                      $time, name, exp, got));
    endtask

    task automatic expected_result(input alu_op_t o, input sel_a_t sa, input sel_b_t sb,
                                   input logic w, input logic [xlen-1:0] pc_v,
                                   input logic [xlen-1:0] rs1_v, input logic [xlen-1:0] rs2_v,
                                   input logic [xlen-1:0] csr_v, input logic [xlen-1:0] imm_v,
                                   output logic [xlen-1:0] exp);
        logic [xlen-1:0] av;
        logic [xlen-1:0] bv;
        logic [xlen-1:0] wide;
        logic [xlen-1:0] min_neg;
        logic [5:0]      sh;
        logic            ovf;
        min_neg = {1'b1, {(xlen-1){1'b0}}};
        if (sa == sel_a_pc) av = pc_v;
        else if (w) av = {32'h0, rs1_v[31:0]};
        else av = rs1_v;
        case (sb)
            sel_b_rs2: bv = rs2_v;
            sel_b_csr: bv = csr_v;
            default:   bv = imm_v;
        endcase
        sh  = bv[5:0];
        ovf = (av == min_neg) && (bv == {xlen{1'b1}});
        case (o)
            op_add:    exp = av + bv;
            op_sub:    exp = av - bv;
            op_pass_a: exp = av;
            op_pass_b: exp = bv;
            op_xor:    exp = av ^ bv;
            op_or:     exp = av | bv;
            op_and:    exp = av & bv;
            op_sll:    exp = av << sh;
            op_srl:    exp = av >> sh;
            op_sra: begin
                if (w) begin
                    // Sign-extend the low word, shift, then keep the low word only.
                    wide = $signed({{32{av[31]}}, av[31:0]}) >>> sh;
                    exp  = {32'h0, wide[31:0]};
                end else begin
                    exp = $signed(av) >>> sh;
                end
            end
            op_slt:    exp = ($signed(av) < $signed(bv)) ? 64'd1 : 64'd0;
            op_sltu:   exp = (av < bv) ? 64'd1 : 64'd0;
            op_eq:     exp = (av == bv) ? 64'd1 : 64'd0;
            op_ge:     exp = ($signed(av) >= $signed(bv)) ? 64'd1 : 64'd0;
            op_geu:    exp = (av >= bv) ? 64'd1 : 64'd0;
            op_mul:    exp = av * bv;
            op_div: begin
                if (bv == '0) exp = {xlen{1'b1}};
                else if (ovf) exp = av;
                else exp = $signed(av) / $signed(bv);
            end
            op_divu:   exp = (bv == '0) ? {xlen{1'b1}} : av / bv;
            op_rem: begin
                if (bv == '0) exp = av;
                else if (ovf) exp = '0;
                else exp = $signed(av) % $signed(bv);
            end
            default:   exp = (bv == '0) ? av : av % bv;
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checking tasks
    //////////////////////////////////////////////////////////////////////

    task automatic start_op(input alu_op_t o, input sel_a_t sa, input sel_b_t sb,
                            input logic w, input logic [xlen-1:0] pc_v,
                            input logic [xlen-1:0] rs1_v, input logic [xlen-1:0] rs2_v,
                            input logic [xlen-1:0] csr_v, input logic [xlen-1:0] imm_v,
                            input logic fl);
        @(posedge clk);
        op       <= o;
        sel_a    <= sa;
        sel_b    <= sb;
        op_w     <= w;
        pc       <= pc_v;
        rs1      <= rs1_v;
        rs2      <= rs2_v;
        csr      <= csr_v;
        imm      <= imm_v;
        flush    <= fl;
        in_valid <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
        flush    <= 1'b0;
    endtask

    task automatic run_op(input alu_op_t o, input sel_a_t sa, input sel_b_t sb,
                          input logic w, input logic [xlen-1:0] pc_v,
                          input logic [xlen-1:0] rs1_v, input logic [xlen-1:0] rs2_v,
                          input logic [xlen-1:0] csr_v, input logic [xlen-1:0] imm_v);
        logic [xlen-1:0] exp;
        logic            multi;
        int              cycles;
        multi = (o == op_mul) || (o == op_div) || (o == op_divu) ||
                (o == op_rem) || (o == op_remu);
        expected_result(o, sa, sb, w, pc_v, rs1_v, rs2_v, csr_v, imm_v, exp);
        start_op(o, sa, sb, w, pc_v, rs1_v, rs2_v, csr_v, imm_v, 1'b0);
        @(negedge clk);
        if (!multi) begin
            check_value("out_valid", out_valid, 1);
            check_value("busy", busy, 0);
        end else begin
            check_value("out_valid", out_valid, 0);
            cycles = 0;
            while (!out_valid) begin
                check_value("busy", busy, 1);
                cycles++;
                if (cycles > 200) begin
                    stop_on_failure($sformatf("Timeout: no out_valid for op %0d", o));
                end
                @(negedge clk);
            end
            check_value("busy", busy, 0);
        end
        check_value("res", res, exp);
    endtask

    task automatic run_random(input alu_op_t o);
        logic [xlen-1:0] r;
        sel_a_t          sa;
        sel_b_t          sb;
        r  = rand_bits(4);
        sa = r[0] ? sel_a_rs1 : sel_a_pc;
        case (r[3:2])
            2'd0:    sb = sel_b_imm;
            2'd2:    sb = sel_b_csr;
            default: sb = sel_b_rs2;
        endcase
        run_op(o, sa, sb, r[1], rand_bits(64), rand_bits(64), rand_bits(64),
               rand_bits(64), rand_bits(64));
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
        end
    endtask

    // Flush a multi-cycle op some cycles after it was issued.
    task automatic run_flushed(input alu_op_t o, input int delay);
        start_op(o, sel_a_rs1, sel_b_rs2, 1'b0, '0, rand_bits(64),
                 rand_bits(32) | 64'd1, '0, '0, 1'b0);
        @(negedge clk);
        check_value("busy", busy, 1);
        repeat (delay) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("out_valid", out_valid, 0);
        expect_quiet(mul_steps + 8);
    endtask

    task automatic run_cancelled(input alu_op_t o);
        start_op(o, sel_a_rs1, sel_b_rs2, 1'b0, '0, rand_bits(64), rand_bits(64),
                 '0, '0, 1'b1);
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("out_valid", out_valid, 0);
        expect_quiet(mul_steps + 8);
    endtask

    task automatic check_operand_select();
        sel_a_t sa;
        sel_b_t sb;
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 3; j++) begin
                for (int w = 0; w < 2; w++) begin
                    sa = (i == 1) ? sel_a_rs1 : sel_a_pc;
                    sb = (j == 0) ? sel_b_imm : (j == 1) ? sel_b_rs2 : sel_b_csr;
                    run_op(op_pass_a, sa, sb, w[0], rand_bits(64), rand_bits(64),
                           rand_bits(64), rand_bits(64), rand_bits(64));
                    run_op(op_pass_b, sa, sb, w[0], rand_bits(64), rand_bits(64),
                           rand_bits(64), rand_bits(64), rand_bits(64));
                end
            end
        end
        // Word sra with a negative and a positive low word.
        for (int s = 0; s < 64; s += 7) begin
            run_op(op_sra, sel_a_rs1, sel_b_imm, 1'b1, '0,
                   (rand_bits(32) << 32) | 64'h8000_0000 | rand_bits(31), '0, '0, s);
            run_op(op_sra, sel_a_rs1, sel_b_imm, 1'b1, '0,
                   (rand_bits(32) << 32) | rand_bits(31), '0, '0, s);
        end
    endtask

    task automatic check_divide();
        logic [4:0] k;
        for (k = 5'd16; k <= 5'd19; k = k + 5'd1) begin
            for (int n = 0; n < 6; n++) begin
                run_random(alu_op_t'(k));
            end
            run_op(alu_op_t'(k), sel_a_rs1, sel_b_rs2, 1'b0, '0, rand_bits(64),
                   rand_bits(10), '0, '0);
            run_op(alu_op_t'(k), sel_a_rs1, sel_b_rs2, 1'b0, '0, rand_bits(64),
                   -rand_bits(10), '0, '0);
            run_op(alu_op_t'(k), sel_a_rs1, sel_b_rs2, 1'b0, '0, rand_bits(64),
                   '0, '0, '0);
            run_op(alu_op_t'(k), sel_a_rs1, sel_b_rs2, 1'b0, '0,
                   {1'b1, {(xlen-1){1'b0}}}, {xlen{1'b1}}, '0, '0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [4:0] k;
        rst_n    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        op       = op_add;
        sel_a    = sel_a_pc;
        sel_b    = sel_b_imm;
        op_w     = 1'b0;
        pc       = '0;
        rs1      = '0;
        rs2      = '0;
        csr      = '0;
        imm      = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("out_valid", out_valid, 0);
        check_value("busy", busy, 0);

        for (k = 5'd0; k <= 5'd14; k = k + 5'd1) begin
            for (int n = 0; n < 8; n++) begin
                run_random(alu_op_t'(k));
            end
        end
        check_operand_select();
        for (int n = 0; n < 12; n++) begin
            run_random(op_mul);
        end
        check_divide();

        run_flushed(op_mul, 10);
        run_random(op_mul);
        run_flushed(op_div, 20);
        run_random(op_div);
        run_flushed(op_remu, 1);
        run_cancelled(op_mul);
        run_cancelled(op_add);
        run_random(op_add);
        run_random(op_rem);

        $display("No errors");
        $finish;
    end

endmodule

// File: flist.f
hw/exu_pkg.sv
hw/exu_operand_mux.sv
hw/exu_alu.sv
hw/exu_mul.sv
hw/exu_div.sv
hw/exu_ctrl.sv
hw/exu_top.sv
tests/exu_tb.sv
